/* build.f */
uart_pkg.sv
uart_bit_timer.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
ahb_uart.sv
tb_ahb_uart.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= tb_ahb_uart
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_ahb_uart.sv */
// Testbench for the AHB-Lite UART: bus access, loopback frames, status flags and overrun
module tb_ahb_uart;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_ENTRIES = 8;        // Stimulus table rows
    localparam logic [31:0] ADDR_TXDATA = 32'h0;
    localparam logic [31:0] ADDR_RXDATA = 32'h4;
    localparam logic [31:0] ADDR_STATUS = 32'h8;
    localparam logic [31:0] ADDR_BAUD   = 32'hC;

    logic        hclk;
    logic        reset;
    logic [31:0] haddr_s;
    logic [31:0] hwdata_s;
    logic [31:0] hrdata_s;
    logic        hwrite_s;
    logic [1:0]  htrans_s;
    logic [2:0]  hsize_s;
    logic [2:0]  hburst_s;
    logic [1:0]  hresp_s;
    logic        hready_s;
    logic        hsel_s;
    wire         serial_line;                       // Loopback tx to rx

    int          errors;
    int          cycles;
    int          cycle_limit;
    int          seed;
    logic [15:0] div_tab  [NUM_ENTRIES];            // Clocks per bit
    logic [7:0]  byte_tab [NUM_ENTRIES];            // Byte sent
    logic [31:0] rd_word;
    logic [7:0]  rx_byte_seen;                      // Decoded from the line
    logic [7:0]  ov_first;
    logic [7:0]  ov_second;

    ahb_uart ahb_uart_inst (
        .hclk     (hclk),
        .reset    (reset),
        .haddr_s  (haddr_s),
        .hwdata_s (hwdata_s),
        .hrdata_s (hrdata_s),
        .hwrite_s (hwrite_s),
        .htrans_s (htrans_s),
        .hsize_s  (hsize_s),
        .hburst_s (hburst_s),
        .hresp_s  (hresp_s),
        .hready_s (hready_s),
        .hsel_s   (hsel_s),
        .uart_tx  (serial_line),
        .uart_rx  (serial_line)
    );

    always #2 hclk = ~hclk;                         // 4 ns period

    // Abort if the run overstays its budget
    always @(posedge hclk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_response();
        compare_word("hready_s", 32'd1, {31'd0, hready_s});
        compare_word("hresp_s", 32'd0, {30'd0, hresp_s});     // OKAY
    endtask

    // Address phase, then data phase; the write lands on the following edge
    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= 2'b10;                          // NONSEQ
        hwrite_s <= 1'b1;
        haddr_s  <= addr;
        @(posedge hclk);
        hsel_s   <= 1'b0;
        htrans_s <= 2'b00;
        hwrite_s <= 1'b0;
        hwdata_s <= data;
        @(negedge hclk);
        check_response();
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= 2'b10;
        hwrite_s <= 1'b0;
        haddr_s  <= addr;
        @(posedge hclk);
        hsel_s   <= 1'b0;
        htrans_s <= 2'b00;
        @(negedge hclk);                            // Mid data phase
        data = hrdata_s;
        check_response();
    endtask

    // Mid-bit sampling of one 8N1 frame
    task automatic decode_frame(input logic [15:0] div, output logic [7:0] value);
        @(negedge serial_line);                     // Start bit edge
        repeat (div / 2) @(negedge hclk);
        compare_word("uart_tx start bit", 32'd0, {31'd0, serial_line});
        for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge hclk);
            value[i] = serial_line;                 // LSB first
        end
        repeat (div) @(negedge hclk);
        compare_word("uart_tx stop bit", 32'd1, {31'd0, serial_line});
    endtask

    // Poll STATUS until idle transmitter and the given flag
    task automatic wait_frame_done(input int flag_bit);
        logic [31:0] status;
        status = 32'h1;
        while (status[uart_pkg::STAT_TX_BUSY] || !status[flag_bit])
            ahb_read(ADDR_STATUS, status);
    endtask

    task automatic check_line_idle(input logic [15:0] div);
        logic went_low;
        went_low = 1'b0;
        repeat (2 * div) begin
            @(negedge hclk);
            went_low = went_low | !serial_line;
        end
        if (went_low) begin
            errors++;
            $display("At %0t ns: uart_tx started another frame after a write made while busy",
                     $time);
        end
    endtask

    initial begin
        hclk     = 1'b0;
        errors   = 0;
        cycles   = 0;
        seed     = 45;
        reset    <= 1'b1;
        haddr_s  <= 32'd0;
        hwdata_s <= 32'd0;
        hwrite_s <= 1'b0;
        htrans_s <= 2'b00;
        hsize_s  <= 3'b010;                         // Word
        hburst_s <= 3'b000;
        hsel_s   <= 1'b0;
        div_tab[0]  = 16'd16;
        div_tab[1]  = 16'd4;
        div_tab[2]  = 16'd8;
        div_tab[3]  = 16'd6;
        byte_tab[0] = 8'h00;
        byte_tab[1] = 8'hFF;
        byte_tab[2] = 8'hA5;
        byte_tab[3] = 8'h5A;
        for (int i = 4; i < NUM_ENTRIES; i++) begin
            div_tab[i]  = 16'd4 + 16'($unsigned($random(seed)) % 13);   // 4 to 16
            byte_tab[i] = 8'($random(seed));
        end
        ov_first  = 8'($random(seed));
        ov_second = 8'($random(seed));
        cycle_limit = 2 * (12 * div_tab[NUM_ENTRIES-1] + 200);         // Overrun frames
        for (int i = 0; i < NUM_ENTRIES; i++)
            cycle_limit += 12 * div_tab[i] + 200;

        repeat (4) @(posedge hclk);
        reset <= 1'b0;

        ahb_read(ADDR_STATUS, rd_word);
        compare_word("STATUS after reset", 32'd0, rd_word);
        ahb_read(ADDR_BAUD, rd_word);
        compare_word("BAUD after reset", {16'd0, uart_pkg::BAUD_RESET}, rd_word);
        compare_word("uart_tx after reset", 32'd1, {31'd0, serial_line});

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ahb_write(ADDR_BAUD, {16'hA5C3, div_tab[i]});          // Upper half ignored
            ahb_read(ADDR_BAUD, rd_word);
            compare_word("BAUD", {16'd0, div_tab[i]}, rd_word);
            fork
                decode_frame(div_tab[i], rx_byte_seen);
                begin
                    ahb_write(ADDR_TXDATA, {24'd0, byte_tab[i]});
                    ahb_read(ADDR_STATUS, rd_word);
                    compare_word("STATUS busy bit", 32'd1 << uart_pkg::STAT_TX_BUSY,
                                 rd_word & (32'd1 << uart_pkg::STAT_TX_BUSY));
                    ahb_write(ADDR_TXDATA, {24'd0, ~byte_tab[i]});  // Lands while busy
                end
            join
            compare_word("uart_tx byte", {24'd0, byte_tab[i]}, {24'd0, rx_byte_seen});
            wait_frame_done(uart_pkg::STAT_RX_VALID);
            ahb_read(ADDR_STATUS, rd_word);
            compare_word("STATUS after frame", 32'd1 << uart_pkg::STAT_RX_VALID, rd_word);
            check_line_idle(div_tab[i]);
            ahb_read(ADDR_RXDATA, rd_word);
            compare_word("RXDATA", {24'd0, byte_tab[i]}, rd_word);
            ahb_read(ADDR_STATUS, rd_word);
            compare_word("STATUS after RXDATA read", 32'd0, rd_word);
        end

        // Second byte arrives before the first is read
        ahb_write(ADDR_TXDATA, {24'd0, ov_first});
        wait_frame_done(uart_pkg::STAT_RX_VALID);
        ahb_write(ADDR_TXDATA, {24'd0, ov_second});
        wait_frame_done(uart_pkg::STAT_RX_OVERRUN);
        ahb_read(ADDR_STATUS, rd_word);
        compare_word("STATUS overrun",
                     (32'd1 << uart_pkg::STAT_RX_VALID) | (32'd1 << uart_pkg::STAT_RX_OVERRUN),
                     rd_word);
        ahb_read(ADDR_RXDATA, rd_word);
        compare_word("RXDATA after overrun", {24'd0, ov_second}, rd_word);
        ahb_read(ADDR_STATUS, rd_word);
        compare_word("STATUS after overrun read", 32'd0, rd_word);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule : tb_ahb_uart

/* ahb_uart.sv */
// AHB-Lite UART peripheral top: bus slave front end, register block and both serial engines
module ahb_uart (
    input  logic        hclk,           // Bus clock
    input  logic        reset,          // Sync, active high
    input  logic [31:0] haddr_s,        // Address phase
    input  logic [31:0] hwdata_s,       // Data phase
    output logic [31:0] hrdata_s,       // Read mux out
    input  logic        hwrite_s,       // Write flag
    input  logic [1:0]  htrans_s,       // Transfer type
    input  logic [2:0]  hsize_s,        // Accepted, no effect
    input  logic [2:0]  hburst_s,       // Accepted, no effect
    output logic [1:0]  hresp_s,        // Always OKAY
    output logic        hready_s,       // No wait states
    input  logic        hsel_s,         // Slave select
    output logic        uart_tx,        // Serial out
    input  logic        uart_rx         // Serial in
);

    logic                            request;      // Valid address phase
    logic                            wr_pending;   // Write in data phase
    logic                            rd_pending;   // Read in data phase
    uart_pkg::uart_reg_e             reg_idx;      // Held address-phase index
    logic                            rd_en;        // RXDATA read strobe
    logic                            tx_start;
    logic [7:0]                      tx_byte;
    logic                            tx_busy;
    logic                            rx_done;
    logic [7:0]                      rx_byte;
    logic [uart_pkg::BAUD_W-1:0]     baud_div;

    assign request = hsel_s && (htrans_s != uart_pkg::HTRANS_IDLE);

    // Address phase capture, data phase follows next cycle
    always_ff @(posedge hclk) begin
        if (reset) begin
            wr_pending <= 1'b0;
            rd_pending <= 1'b0;
            reg_idx    <= uart_pkg::REG_TXDATA;
        end else begin
            wr_pending <= request && hwrite_s;
            rd_pending <= request && !hwrite_s;
            if (request)
                reg_idx <= uart_pkg::uart_reg_e'(haddr_s[3:2]);  // Word index only
        end
    end

    assign rd_en    = rd_pending && (reg_idx == uart_pkg::REG_RXDATA);  // Pops flags
    assign hready_s = 1'b1;                     // Zero wait states
    assign hresp_s  = uart_pkg::HRESP_OKAY;

    uart_regs uart_regs_inst (
        .hclk     (hclk),
        .reset    (reset),
        .wr_en    (wr_pending),
        .rd_en    (rd_en),
        .reg_idx  (reg_idx),
        .wdata    (hwdata_s),
        .tx_busy  (tx_busy),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte),
        .rdata    (hrdata_s),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .baud_div (baud_div)
    );

    uart_tx uart_tx_inst (
        .hclk     (hclk),
        .reset    (reset),
        .start    (tx_start),
        .data     (tx_byte),
        .baud_div (baud_div),
        .busy     (tx_busy),
        .txd      (uart_tx)
    );

    uart_rx uart_rx_inst (
        .hclk     (hclk),
        .reset    (reset),
        .rxd      (uart_rx),
        .baud_div (baud_div),
        .done     (rx_done),
        .data     (rx_byte)
    );

endmodule : ahb_uart

/* uart_regs.sv */
// UART register file: divider, receive byte and flags, read mux and transmit start strobe
module uart_regs (
    input  logic                        hclk,
    input  logic                        reset,
    input  logic                        wr_en,      // Data-phase write
    input  logic                        rd_en,      // Data-phase RXDATA read
    input  uart_pkg::uart_reg_e         reg_idx,    // Held bus index
    input  logic [31:0]                 wdata,      // hwdata
    input  logic                        tx_busy,    // From transmitter
    input  logic                        rx_done,    // Byte accepted by receiver
    input  logic [7:0]                  rx_byte,
    output logic [31:0]                 rdata,      // Combinational read mux
    output logic                        tx_start,   // One-cycle pulse
    output logic [7:0]                  tx_byte,
    output logic [uart_pkg::BAUD_W-1:0] baud_div
);

    logic [7:0] rx_hold;        // Last received byte
    logic       rx_valid;
    logic       rx_overrun;
    logic       tx_write;       // TXDATA write accepted

    // Busy or a start already in flight drops the write
    assign tx_write = wr_en && (reg_idx == uart_pkg::REG_TXDATA) && !tx_busy && !tx_start;

    // Divider and transmit strobe
    always_ff @(posedge hclk) begin
        if (reset) begin
            baud_div <= uart_pkg::BAUD_RESET;
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_write;               // High for one cycle
            if (wr_en && (reg_idx == uart_pkg::REG_BAUD))
                baud_div <= wdata[uart_pkg::BAUD_W-1:0];
        end
    end

    // Byte handed to the transmitter with the strobe
    always_ff @(posedge hclk) begin
        if (tx_write)
            tx_byte <= wdata[7:0];
    end

    // Receive flags, new byte beats a same-cycle read
    always_ff @(posedge hclk) begin
        if (reset) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else if (rx_done) begin
            rx_valid   <= 1'b1;
            rx_overrun <= (rx_overrun || rx_valid) && !rd_en;  // Unread byte lost
        end else if (rd_en) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end
    end

    always_ff @(posedge hclk) begin
        if (rx_done)
            rx_hold <= rx_byte;                 // Overwrites unread byte
    end

    // Read mux, unused bits zero
    always_comb begin
        rdata = 32'd0;
        case (reg_idx)
            uart_pkg::REG_TXDATA: rdata = 32'd0;            // Write only
            uart_pkg::REG_RXDATA: rdata[7:0] = rx_hold;
            uart_pkg::REG_STATUS: begin
                rdata[uart_pkg::STAT_TX_BUSY]    = tx_busy;
                rdata[uart_pkg::STAT_RX_VALID]   = rx_valid;
                rdata[uart_pkg::STAT_RX_OVERRUN] = rx_overrun;
            end
            uart_pkg::REG_BAUD:   rdata[uart_pkg::BAUD_W-1:0] = baud_div;
            default:              rdata = 32'd0;
        endcase
    end

endmodule : uart_regs

/* uart_rx.sv */
// UART receiver: start-bit recheck at half bit, mid-bit sampling, byte out on a good stop bit
module uart_rx (
    input  logic                        hclk,
    input  logic                        reset,
    input  logic                        rxd,        // Async serial line
    input  logic [uart_pkg::BAUD_W-1:0] baud_div,
    output logic                        done,       // One-cycle byte pulse
    output logic [7:0]                  data        // Assembled byte
);

    uart_pkg::rx_state_e state;
    logic                rxd_meta;      // First sync stage
    logic                rxd_sync;      // Safe to sample
    logic [2:0]          bit_idx;
    logic                restart;
    logic                bit_tick;
    logic                half_tick;

    // Two-flop synchronizer, idles high
    always_ff @(posedge hclk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Restart on falling edge, then again at mid start bit to align later ticks
    assign restart = ((state == uart_pkg::RX_IDLE) && !rxd_sync) ||
                     ((state == uart_pkg::RX_START) && half_tick && !rxd_sync);

    uart_bit_timer bit_timer_inst (
        .hclk      (hclk),
        .reset     (reset),
        .enable    (state != uart_pkg::RX_IDLE),
        .restart   (restart),
        .baud_div  (baud_div),
        .bit_tick  (bit_tick),
        .half_tick (half_tick)
    );

    always_ff @(posedge hclk) begin
        if (reset) begin
            state   <= uart_pkg::RX_IDLE;
            done    <= 1'b0;
            bit_idx <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: if (!rxd_sync)
                    state <= uart_pkg::RX_START;    // Possible start bit
                uart_pkg::RX_START: if (half_tick) begin
                    bit_idx <= '0;
                    state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;  // Glitch?
                end
                uart_pkg::RX_DATA: if (bit_tick) begin
                    if (bit_idx == 3'(uart_pkg::DATA_BITS - 1))
                        state <= uart_pkg::RX_STOP;
                    bit_idx <= bit_idx + 1'b1;
                end
                uart_pkg::RX_STOP: if (bit_tick) begin
                    done  <= rxd_sync;      // Bad stop drops the byte
                    state <= uart_pkg::RX_IDLE;
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Samples enter at the top, LSB ends at bit 0
    always_ff @(posedge hclk) begin
        if (bit_tick && (state == uart_pkg::RX_DATA))
            data <= {rxd_sync, data[7:1]};
    end

endmodule : uart_rx

/* uart_tx.sv */
// UART transmitter: 8N1 frame from a start pulse, one bit per divider period
module uart_tx (
    input  logic                        hclk,
    input  logic                        reset,
    input  logic                        start,      // One-cycle request
    input  logic [7:0]                  data,       // Byte to send
    input  logic [uart_pkg::BAUD_W-1:0] baud_div,
    output logic                        busy,       // Frame in flight
    output logic                        txd         // Serial line
);

    uart_pkg::tx_state_e state;
    logic [7:0]          shift;         // Remaining data bits
    logic [2:0]          bit_idx;       // Data bit counter
    logic                restart;
    logic                bit_tick;

    assign restart = start && (state == uart_pkg::TX_IDLE);
    assign busy    = (state != uart_pkg::TX_IDLE);     // Rises the cycle after start

    uart_bit_timer bit_timer_inst (
        .hclk      (hclk),
        .reset     (reset),
        .enable    (busy),
        .restart   (restart),
        .baud_div  (baud_div),
        .bit_tick  (bit_tick),
        .half_tick ()                   // Not needed on transmit
    );

    always_ff @(posedge hclk) begin
        if (reset) begin
            state   <= uart_pkg::TX_IDLE;
            txd     <= 1'b1;            // Idle line high
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: if (restart) begin
                    state <= uart_pkg::TX_START;
                    txd   <= 1'b0;      // Start bit
                end
                uart_pkg::TX_START: if (bit_tick) begin
                    state   <= uart_pkg::TX_DATA;
                    txd     <= shift[0];            // LSB first
                    bit_idx <= '0;
                end
                uart_pkg::TX_DATA: if (bit_tick) begin
                    if (bit_idx == 3'(uart_pkg::DATA_BITS - 1)) begin
                        state <= uart_pkg::TX_STOP;
                        txd   <= 1'b1;  // Stop bit
                    end else begin
                        txd     <= shift[1];
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                uart_pkg::TX_STOP: if (bit_tick)
                    state <= uart_pkg::TX_IDLE;     // Busy drops here
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Shift register, loaded at start, moves on each data bit
    always_ff @(posedge hclk) begin
        if (restart)
            shift <= data;
        else if (bit_tick && (state == uart_pkg::TX_DATA))
            shift <= shift >> 1;
    end

endmodule : uart_tx

/* uart_bit_timer.sv */
// Baud counter shared by both engines: full-bit tick every divider period, one half-bit tick
module uart_bit_timer (
    input  logic                        hclk,
    input  logic                        reset,
    input  logic                        enable,     // Low holds count at zero
    input  logic                        restart,    // Reload and rearm half tick
    input  logic [uart_pkg::BAUD_W-1:0] baud_div,   // Clocks per bit
    output logic                        bit_tick,   // Last cycle of each bit
    output logic                        half_tick   // Once per restart
);

    logic [uart_pkg::BAUD_W-1:0] count;
    logic                        half_armed;    // Half tick still owed
    logic [uart_pkg::BAUD_W-1:0] half_last;     // Count value at half period

    assign half_last = (baud_div >> 1) - 1'b1;

    always_ff @(posedge hclk) begin
        if (reset) begin
            count      <= '0;
            half_armed <= 1'b0;
        end else if (restart) begin
            count      <= '0;                   // Restart beats enable
            half_armed <= 1'b1;
        end else if (!enable) begin
            count      <= '0;
            half_armed <= 1'b0;
        end else begin
            count <= bit_tick ? '0 : count + 1'b1;  // Wrap at divider
            if (half_tick)
                half_armed <= 1'b0;
        end
    end

    assign bit_tick  = enable && !restart && (count == baud_div - 1'b1);
    assign half_tick = enable && half_armed && (count == half_last);  // May itself cause restart

endmodule : uart_bit_timer

/* uart_pkg.sv */
// Shared UART definitions: register map, FSM states, AHB codes and reset values, by scoped name
package uart_pkg;

    // Register index from haddr[3:2]
    typedef enum logic [1:0] {
        REG_TXDATA = 2'd0,          // 0x0 transmit byte, write only
        REG_RXDATA = 2'd1,          // 0x4 last received byte
        REG_STATUS = 2'd2,          // 0x8 busy, valid, overrun
        REG_BAUD   = 2'd3           // 0xC clocks per bit
    } uart_reg_e;

    // Transmit FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,            // Line high, waiting for start
        TX_START = 2'd1,            // Driving start bit
        TX_DATA  = 2'd2,            // Shifting data LSB first
        TX_STOP  = 2'd3             // Driving stop bit
    } tx_state_e;

    // Receive FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,            // Waiting for falling edge
        RX_START = 2'd1,            // Recheck at half bit
        RX_DATA  = 2'd2,            // Mid-bit sampling
        RX_STOP  = 2'd3             // Stop bit check
    } rx_state_e;

    // AHB-Lite codes
    localparam logic [1:0] HTRANS_IDLE = 2'b00;     // No transfer
    localparam logic [1:0] HRESP_OKAY  = 2'b00;     // Only response given

    // Frame and divider
    localparam int DATA_BITS = 8;                   // 8N1 only
    localparam int BAUD_W    = 16;                  // Divider width
    localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd16;  // Clocks per bit after reset

    // Status word bit positions
    localparam int STAT_TX_BUSY    = 0;             // Frame in flight
    localparam int STAT_RX_VALID   = 1;             // Unread byte held
    localparam int STAT_RX_OVERRUN = 2;             // Byte lost before read

endpackage : uart_pkg
